// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module agusec_tb -f agusec_unit.f -o agusec_sim
	./obj_dir/agusec_sim > sim.log 2>&1 || true
	cat sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== agusec_unit.f ====
source/agusec_pkg.sv
source/agusec_upper_check.sv
source/agusec_range.sv
source/agusec_lane.sv
source/agusec_collect.sv
source/agusec_dispatch.sv
source/agusec_unit.sv
tests/agusec_clock.sv
tests/agusec_tb.sv

// ==== source/agusec_collect.sv ====
`timescale 1ns/1ps

module agusec_collect #(
  parameter int LANES = 4,
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [LANES-1:0]       res_valid,
  input  agusec_pkg::check_res_t res [LANES],
  input  logic                   pop,
  output logic                   res_avail,
  output agusec_pkg::check_res_t head
);

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  agusec_pkg::check_res_t mem [QUEUE_DEPTH];
  agusec_pkg::check_res_t sel;
  logic [PTR_W-1:0]       wr_ptr;
  logic [PTR_W-1:0]       rd_ptr;
  logic [CNT_W-1:0]       count;
  logic                   push;
  logic                   full;

  // lanes finish in issue order and one at a time
  always_comb
  begin
    sel = '0;
    for (int i = 0; i < LANES; i++)
    begin
      if (res_valid[i])
        sel = res[i];
    end
  end

  assign push      = |res_valid;
  assign full      = count == QUEUE_DEPTH;
  assign res_avail = count != '0;
  assign head      = mem[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= sel;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  a_one_result: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(res_valid));
  // dispatch back-pressure keeps the queue from overflowing
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full || pop);
  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) pop |-> res_avail);

endmodule

// ==== source/agusec_dispatch.sv ====
`timescale 1ns/1ps

module agusec_dispatch #(
  parameter int LANES = 4,
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  agusec_pkg::reg_addr_e  wb_adr,
  input  logic [63:0]            wb_dat_w,
  output logic [63:0]            wb_dat_r,
  output logic                   wb_ack,
  output agusec_pkg::check_req_t req,
  output logic [LANES-1:0]       issue,
  input  logic                   res_avail,
  input  agusec_pkg::check_res_t head,
  output logic                   pop
);

  localparam int RR_W = (LANES > 1) ? $clog2(LANES) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  agusec_pkg::cap_ptr_t                ptr_q;
  logic [agusec_pkg::ADDR_W-1:0]       opa_q;
  logic [agusec_pkg::ADDR_W-1:0]       opb_q;
  logic [7:0]                          tag_q;
  logic [RR_W-1:0]                     rr_q;
  logic [CNT_W-1:0]                    cnt_q;
  logic                                bus_req;
  logic                                room;
  logic                                launch;
  logic                                read_go;
  logic                                ack_go;

  assign bus_req = wb_cyc && wb_stb && !wb_ack; // new cycle rather than the ack beat
  assign room    = cnt_q < QUEUE_DEPTH;
  assign launch  = bus_req && wb_we && wb_adr == agusec_pkg::REG_OPB_GO && room;
  assign read_go = bus_req && !wb_we && wb_adr == agusec_pkg::REG_RESULT && res_avail;
  assign ack_go  = launch || read_go ||
                   (bus_req && wb_we && wb_adr != agusec_pkg::REG_OPB_GO) ||
                   (bus_req && !wb_we && wb_adr != agusec_pkg::REG_RESULT);

  assign req = '{ptr: ptr_q, opa: opa_q, opb: opb_q, tag: tag_q};

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wb_ack <= 1'b0;
      issue  <= '0;
      pop    <= 1'b0;
      tag_q  <= '0;
      rr_q   <= '0;
      cnt_q  <= '0;
    end
    else
    begin
      wb_ack <= ack_go;
      pop    <= read_go;
      issue  <= launch ? (LANES'(1) << rr_q) : '0;
      if (launch)
        rr_q <= (rr_q == RR_W'(LANES - 1)) ? '0 : rr_q + 1'b1;
      if (|issue)
        tag_q <= tag_q + 8'd1; // wraps at 8 bits
      if (|issue && !pop)
        cnt_q <= cnt_q + 1'b1;
      else if (!(|issue) && pop)
        cnt_q <= cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (bus_req && wb_we && wb_adr == agusec_pkg::REG_PTR)
      ptr_q <= agusec_pkg::cap_ptr_t'(wb_dat_w);
    if (bus_req && wb_we && wb_adr == agusec_pkg::REG_OPA)
      opa_q <= wb_dat_w[agusec_pkg::ADDR_W-1:0];
    if (launch)
      opb_q <= wb_dat_w[agusec_pkg::ADDR_W-1:0];
    wb_dat_r <= read_go ? {{(64 - $bits(agusec_pkg::check_res_t)){1'b0}}, head} : '0;
  end

  a_issue_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(issue));
  a_cnt_limit: assert property (@(posedge clk) disable iff (!rst_n) cnt_q <= QUEUE_DEPTH);

endmodule

// ==== source/agusec_lane.sv ====
`timescale 1ns/1ps

module agusec_lane (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   issue,
  input  agusec_pkg::check_req_t req,
  output logic                   res_valid,
  output agusec_pkg::check_res_t res
);

  logic                          s1_valid;
  logic [agusec_pkg::ADDR_W-1:0] s1_eff;
  agusec_pkg::cap_ptr_t          s1_ptr;
  logic [7:0]                    s1_tag;
  logic                          hi_less;
  logic                          upper_eq;
  logic                          upper_next;
  logic                          below;
  logic                          above;
  agusec_pkg::fault_e            fault;

  // stage 1 effective address
  always_ff @(posedge clk)
  begin
    if (issue)
    begin
      s1_eff <= req.opa + req.opb;
      s1_ptr <= req.ptr;
      s1_tag <= req.tag;
    end
  end

  agusec_upper_check u_upper (
    .ptr        (s1_ptr),
    .eff        (s1_eff),
    .hi_less    (hi_less),
    .upper_eq   (upper_eq),
    .upper_next (upper_next)
  );

  agusec_range u_range (
    .ptr   (s1_ptr),
    .eff   (s1_eff),
    .below (below),
    .above (above)
  );

  always_comb
  begin
    fault = agusec_pkg::FAULT_NONE;
    if (&s1_ptr.exp)
      fault = agusec_pkg::FAULT_NONE; // full address space
    else if (!hi_less)
    begin
      if (!upper_eq)
        fault = agusec_pkg::FAULT_UPPER;
      else if (below)
        fault = agusec_pkg::FAULT_BELOW;
      else if (above)
        fault = agusec_pkg::FAULT_ABOVE;
    end
    else if (upper_eq)
      fault = below ? agusec_pkg::FAULT_BELOW : agusec_pkg::FAULT_NONE;
    else if (upper_next)
      fault = above ? agusec_pkg::FAULT_ABOVE : agusec_pkg::FAULT_NONE;
    else
      fault = agusec_pkg::FAULT_UPPER;
  end

  // stage 2 verdict
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      s1_valid  <= 1'b0;
      res_valid <= 1'b0;
    end
    else
    begin
      s1_valid  <= issue;
      res_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk)
  begin
    if (s1_valid)
      res <= '{fault: fault, pass: fault == agusec_pkg::FAULT_NONE, tag: s1_tag};
  end

endmodule

// ==== source/agusec_pkg.sv ====
package agusec_pkg;

  // field widths of the compressed pointer
  localparam int ADDR_W = 40;
  localparam int EXP_W = 5;

  typedef struct packed {
    logic [3:0]        reserved;
    logic              on_low;
    logic [EXP_W-1:0]  exp;
    logic [6:0]        hi;
    logic [6:0]        low;
    logic [ADDR_W-1:0] addr;
  } cap_ptr_t;

  typedef struct packed {
    cap_ptr_t          ptr;
    logic [ADDR_W-1:0] opa;
    logic [ADDR_W-1:0] opb;
    logic [7:0]        tag;
  } check_req_t;

  typedef enum logic [1:0] {
    FAULT_NONE  = 2'd0,
    FAULT_BELOW = 2'd1,
    FAULT_ABOVE = 2'd2,
    FAULT_UPPER = 2'd3
  } fault_e;

  // fault on top so the struct lines up with the read data word
  typedef struct packed {
    fault_e     fault;
    logic       pass;
    logic [7:0] tag;
  } check_res_t;

  // wishbone word addresses
  typedef enum logic [1:0] {
    REG_PTR    = 2'd0,
    REG_OPA    = 2'd1,
    REG_OPB_GO = 2'd2,
    REG_RESULT = 2'd3
  } reg_addr_e;

endpackage

// ==== source/agusec_range.sv ====
`timescale 1ns/1ps

module agusec_range (
  input  agusec_pkg::cap_ptr_t          ptr,
  input  logic [agusec_pkg::ADDR_W-1:0] eff,
  output logic                          below,
  output logic                          above
);

  logic [agusec_pkg::ADDR_W-1:0] shifted;
  logic [7:0]                    window;
  logic [7:0]                    low_ext;
  logic [7:0]                    hi_ext;

  // eight bits from position exp
  assign shifted = eff >> ptr.exp;
  assign window  = shifted[7:0];

  // bounds are stored at half resolution
  assign low_ext = {ptr.low, 1'b0};
  assign hi_ext  = {ptr.hi, 1'b1};

  assign below = window < low_ext;
  assign above = window > hi_ext;

endmodule

// ==== source/agusec_unit.sv ====
`timescale 1ns/1ps

module agusec_unit #(
  parameter int LANES = 4,
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  agusec_pkg::reg_addr_e wb_adr,
  input  logic [63:0]           wb_dat_w,
  output logic [63:0]           wb_dat_r,
  output logic                  wb_ack
);

  agusec_pkg::check_req_t req;
  logic [LANES-1:0]       issue;
  logic [LANES-1:0]       res_valid;
  agusec_pkg::check_res_t lane_res [LANES];
  logic                   res_avail;
  agusec_pkg::check_res_t head;
  logic                   pop;

  agusec_dispatch #(
    .LANES       (LANES),
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_dispatch (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack),
    .req       (req),
    .issue     (issue),
    .res_avail (res_avail),
    .head      (head),
    .pop       (pop)
  );

  for (genvar i = 0; i < LANES; i++)
  begin : g_lane
    agusec_lane u_lane (
      .clk       (clk),
      .rst_n     (rst_n),
      .issue     (issue[i]),
      .req       (req),
      .res_valid (res_valid[i]),
      .res       (lane_res[i])
    );
  end

  agusec_collect #(
    .LANES       (LANES),
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_collect (
    .clk       (clk),
    .rst_n     (rst_n),
    .res_valid (res_valid),
    .res       (lane_res),
    .pop       (pop),
    .res_avail (res_avail),
    .head      (head)
  );

endmodule

// ==== source/agusec_upper_check.sv ====
`timescale 1ns/1ps

module agusec_upper_check (
  input  agusec_pkg::cap_ptr_t          ptr,
  input  logic [agusec_pkg::ADDR_W-1:0] eff,
  output logic                          hi_less,
  output logic                          upper_eq,
  output logic                          upper_next
);

  logic [5:0]                    shamt;
  logic [agusec_pkg::ADDR_W-1:0] mask;
  logic [agusec_pkg::ADDR_W-1:0] eff_up;
  logic [agusec_pkg::ADDR_W-1:0] ptr_up;
  logic [agusec_pkg::ADDR_W:0]   step;
  logic [agusec_pkg::ADDR_W:0]   ptr_inc;

  // region wraps across a window boundary
  assign hi_less = ptr.hi < ptr.low;

  // bits above exp+7
  assign shamt = {1'b0, ptr.exp} + 6'd8;
  assign mask  = {agusec_pkg::ADDR_W{1'b1}} << shamt;

  assign eff_up = eff & mask;
  assign ptr_up = ptr.addr & mask;

  // one window step in a sum one bit wider so all ones does not wrap to zero
  assign step    = {{agusec_pkg::ADDR_W{1'b0}}, 1'b1} << shamt;
  assign ptr_inc = {1'b0, ptr_up} + step;

  assign upper_eq   = eff_up == ptr_up;
  assign upper_next = {1'b0, eff_up} == ptr_inc;

endmodule

// ==== tests/agusec_clock.sv ====
`timescale 1ns/1ps

module agusec_clock #(
  parameter int PERIOD_NS = 40
) (
  output logic clk
);

  initial
    clk = 1'b0;

  always
    #(PERIOD_NS / 2) clk = ~clk;

endmodule

// ==== tests/agusec_tb.sv ====
`timescale 1ns/1ps

module agusec_tb;

  localparam int LANES = 4;
  localparam int QUEUE_DEPTH = 4;
  localparam int BUS_TIMEOUT = 200;

  logic                   clk;
  logic                   rst_n;
  logic                   wb_cyc;
  logic                   wb_stb;
  logic                   wb_we;
  agusec_pkg::reg_addr_e  wb_adr;
  logic [63:0]            wb_dat_w;
  logic [63:0]            wb_dat_r;
  logic                   wb_ack;
  agusec_pkg::check_res_t exp_q [$];
  logic [63:0]            exp_word = '0;
  logic [31:0]            lcg_state = 32'd82724;
  logic [7:0]             next_tag = 8'd0;
  int                     err_count = 0;
  int                     err_at_start = 0;
  int                     tests_passed = 0;
  int                     tests_failed = 0;

  agusec_clock u_clock (.clk(clk));

  agusec_unit #(
    .LANES       (LANES),
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_agusec_unit (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  a_result_word: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_ack && !wb_we && wb_adr == agusec_pkg::REG_RESULT) |-> (wb_dat_r == exp_word))
    else
    begin
      $display("CHECK FAILED at %0t: wb_dat_r expected %h, actual %h",
               $time, exp_word, $sampled(wb_dat_r));
      err_count++;
    end

  a_plain_read_zero: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_ack && !wb_we && wb_adr != agusec_pkg::REG_RESULT) |-> (wb_dat_r == '0))
    else
    begin
      $display("CHECK FAILED at %0t: wb_dat_r expected %h, actual %h",
               $time, 64'd0, $sampled(wb_dat_r));
      err_count++;
    end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic int rand_below(int n);
    logic [31:0] r;
    r = next_rand();
    return int'(r[30:8]) % n; // low bits of an lcg are weak
  endfunction

  function automatic logic [39:0] rand40();
    logic [31:0] a;
    logic [31:0] b;
    a = next_rand();
    b = next_rand();
    return {a[31:12], b[31:12]};
  endfunction

  function automatic agusec_pkg::cap_ptr_t make_ptr(logic [39:0] addr, int ex,
                                                    logic [6:0] low, logic [6:0] hi);
    agusec_pkg::cap_ptr_t p;
    p = '0;
    p.addr = addr;
    p.exp = 5'(ex);
    p.low = low;
    p.hi = hi;
    return p;
  endfunction

  // effective address near base with the window at ex and the upper part moved by delta
  function automatic logic [39:0] place_window(logic [39:0] base, int ex,
                                               logic [7:0] win, int delta);
    logic [63:0] upper;
    logic [63:0] below_bits;
    logic [63:0] eff;
    upper = (64'(base) >> (ex + 8)) + 64'(delta);
    below_bits = 64'(base) & ((64'd1 << ex) - 64'd1);
    eff = (upper << (ex + 8)) | (64'(win) << ex) | below_bits;
    return eff[39:0];
  endfunction

  function automatic agusec_pkg::check_res_t model_check(agusec_pkg::cap_ptr_t p,
                                                         logic [39:0] opa, logic [39:0] opb,
                                                         logic [7:0] tag);
    logic [63:0]            eff;
    logic [63:0]            win;
    logic [63:0]            up;
    logic [63:0]            ptr_up;
    logic [63:0]            lo2;
    logic [63:0]            hi2;
    agusec_pkg::check_res_t r;
    eff = ({24'd0, opa} + {24'd0, opb}) & 64'h0000_00FF_FFFF_FFFF;
    win = (eff >> p.exp) & 64'hFF;
    up = eff >> (p.exp + 8);
    ptr_up = {24'd0, p.addr} >> (p.exp + 8);
    lo2 = 64'(p.low) * 2;
    hi2 = 64'(p.hi) * 2 + 1;
    r.tag = tag;
    r.fault = agusec_pkg::FAULT_NONE;
    if (p.exp == 5'd31)
      r.fault = agusec_pkg::FAULT_NONE;
    else if (p.hi >= p.low)
    begin
      if (up != ptr_up)
        r.fault = agusec_pkg::FAULT_UPPER;
      else if (win < lo2)
        r.fault = agusec_pkg::FAULT_BELOW;
      else if (win > hi2)
        r.fault = agusec_pkg::FAULT_ABOVE;
    end
    else if (up == ptr_up)
      r.fault = (win < lo2) ? agusec_pkg::FAULT_BELOW : agusec_pkg::FAULT_NONE;
    else if (up == ptr_up + 64'd1)
      r.fault = (win > hi2) ? agusec_pkg::FAULT_ABOVE : agusec_pkg::FAULT_NONE;
    else
      r.fault = agusec_pkg::FAULT_UPPER;
    r.pass = r.fault == agusec_pkg::FAULT_NONE;
    return r;
  endfunction

  function automatic logic [63:0] result_word(agusec_pkg::check_res_t r);
    logic [63:0] w;
    w = '0;
    w[7:0] = r.tag;
    w[8] = r.pass;
    w[10:9] = r.fault;
    return w;
  endfunction

  task automatic close_run();
    $display("tests finished: %0d passed, %0d failed", tests_passed, tests_failed);
    if (tests_failed == 0 && err_count == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  endtask

  task automatic timed_out(string what);
    $display("timeout: %s within %0d cycles", what, BUS_TIMEOUT);
    err_count++;
    tests_failed++;
    close_run();
  endtask

  task automatic start_cycle(logic we, agusec_pkg::reg_addr_e adr, logic [63:0] data,
                             logic [63:0] word);
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we <= we;
    wb_adr <= adr;
    wb_dat_w <= data;
    exp_word <= word;
  endtask

  task automatic wait_for_ack(int limit, output bit acked);
    acked = 1'b0;
    for (int i = 0; i < limit && !acked; i++)
    begin
      @(negedge clk);
      acked = wb_ack;
    end
  endtask

  task automatic end_cycle();
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we <= 1'b0;
  endtask

  task automatic bus_write(agusec_pkg::reg_addr_e adr, logic [63:0] data);
    bit acked;
    start_cycle(1'b1, adr, data, exp_word);
    wait_for_ack(BUS_TIMEOUT, acked);
    if (!acked)
      timed_out("register write never acked");
    end_cycle();
  endtask

  task automatic bus_read(agusec_pkg::reg_addr_e adr);
    bit          acked;
    logic [63:0] word;
    word = '0;
    if (adr == agusec_pkg::REG_RESULT && exp_q.size() == 0)
    begin
      $display("result read attempted with no check outstanding");
      err_count++;
    end
    else
    begin
      if (adr == agusec_pkg::REG_RESULT)
        word = result_word(exp_q.pop_front());
      start_cycle(1'b0, adr, 64'd0, word);
      wait_for_ack(BUS_TIMEOUT, acked);
      if (!acked)
        timed_out("register read never acked");
      end_cycle();
    end
  endtask

  task automatic expect_result(agusec_pkg::cap_ptr_t p, logic [39:0] opa, logic [39:0] opb);
    exp_q.push_back(model_check(p, opa, opb, next_tag));
    next_tag++;
  endtask

  task automatic launch_check(agusec_pkg::cap_ptr_t p, logic [39:0] eff);
    logic [39:0] opb;
    opb = rand40(); // random split keeps the adder carries busy
    bus_write(agusec_pkg::REG_PTR, p);
    bus_write(agusec_pkg::REG_OPA, {24'd0, eff - opb});
    bus_write(agusec_pkg::REG_OPB_GO, {24'd0, opb});
    expect_result(p, eff - opb, opb);
  endtask

  task automatic check_one(agusec_pkg::cap_ptr_t p, logic [39:0] eff);
    launch_check(p, eff);
    bus_read(agusec_pkg::REG_RESULT);
  endtask

  task automatic launch_random();
    int          ex;
    logic [39:0] addr;
    ex = rand_below(32);
    addr = rand40();
    launch_check(make_ptr(addr, ex, 7'(rand_below(128)), 7'(rand_below(128))),
                 place_window(addr, ex, 8'(rand_below(256)), rand_below(3)));
  endtask

  task automatic end_test(string name);
    @(negedge clk); // let the last ack assertion settle
    if (err_count == err_at_start)
    begin
      tests_passed++;
      $display("%s: ok", name);
    end
    else
    begin
      tests_failed++;
      $display("%s: %0d errors", name, err_count - err_at_start);
    end
    err_at_start = err_count;
  endtask

  initial
  begin
    logic [39:0]          base;
    logic [39:0]          eff5;
    agusec_pkg::cap_ptr_t p;
    bit                   acked;
    int                   remaining;
    int                   n;
    rst_n = 1'b0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = agusec_pkg::REG_PTR;
    wb_dat_w = '0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    base = 40'h12_3456_789A; // top bits clear so upper steps stay in range

    p = make_ptr(base, 4, 7'd10, 7'd50);
    bus_write(agusec_pkg::REG_PTR, p);
    bus_read(agusec_pkg::REG_PTR);
    bus_write(agusec_pkg::REG_OPA, 64'd5);
    bus_read(agusec_pkg::REG_OPA);
    bus_read(agusec_pkg::REG_OPB_GO);
    for (int i = 0; i < 3; i++)
      launch_check(p, place_window(base, 4, 8'(40 + i), 0));
    repeat (3) bus_read(agusec_pkg::REG_RESULT);
    end_test("test 1 bus basics");

    for (int ex = 0; ex <= 30; ex += 6)
      check_one(make_ptr(base, ex, 7'd10, 7'd50), place_window(base, ex, 8'(20 + ex * 2), 0));
    end_test("test 2 in bounds");

    for (int ex = 6; ex <= 22; ex += 16)
    begin
      p = make_ptr(base, ex, 7'd10, 7'd50);
      check_one(p, place_window(base, ex, 8'd19, 0));
      check_one(p, place_window(base, ex, 8'd20, 0));
      check_one(p, place_window(base, ex, 8'd101, 0));
      check_one(p, place_window(base, ex, 8'd102, 0));
      check_one(p, place_window(base, ex, 8'd60, 1));
    end
    end_test("test 3 faults");

    for (int ex = 5; ex <= 28; ex += 23)
    begin
      p = make_ptr(base, ex, 7'd100, 7'd20); // hi below low so the region wraps
      check_one(p, place_window(base, ex, 8'd210, 0));
      check_one(p, place_window(base, ex, 8'd150, 0));
      check_one(p, place_window(base, ex, 8'd30, 1));
      check_one(p, place_window(base, ex, 8'd60, 1));
      check_one(p, place_window(base, ex, 8'd30, 2));
    end
    check_one(make_ptr(base, 31, 7'd100, 7'd20), rand40());
    check_one(make_ptr(base, 31, 7'd10, 7'd50), rand40());
    end_test("test 4 wrapped regions");

    p = make_ptr(base, 12, 7'd10, 7'd50);
    repeat (QUEUE_DEPTH) launch_check(p, place_window(base, 12, 8'd70, 0));
    eff5 = place_window(base, 12, 8'd150, 0);
    bus_write(agusec_pkg::REG_OPA, {24'd0, eff5});
    start_cycle(1'b1, agusec_pkg::REG_OPB_GO, 64'd0, exp_word);
    wait_for_ack(20, acked);
    assert (!acked)
    else
    begin
      $display("launch acked at %0t with the result queue full", $time);
      err_count++;
    end
    end_cycle(); // give up the stalled cycle
    if (acked)
      expect_result(p, eff5, 40'd0);
    bus_read(agusec_pkg::REG_RESULT);
    if (!acked)
    begin
      bus_write(agusec_pkg::REG_OPB_GO, 64'd0);
      expect_result(p, eff5, 40'd0);
    end
    while (exp_q.size() > 0)
      bus_read(agusec_pkg::REG_RESULT);
    end_test("test 5 back-pressure");

    remaining = 200;
    while (remaining > 0 || exp_q.size() > 0)
    begin
      n = rand_below(4) + 1;
      for (int i = 0; i < n && remaining > 0 && exp_q.size() < QUEUE_DEPTH; i++)
      begin
        launch_random();
        remaining--;
      end
      n = (remaining == 0) ? exp_q.size() : rand_below(exp_q.size()) + 1;
      repeat (n) bus_read(agusec_pkg::REG_RESULT);
    end
    end_test("test 6 random checks");

    close_run();
  end

endmodule
